// File: rtl/sdu_uart_pkg.sv
`default_nettype none

package sdu_uart_pkg;

    // clk cycles per serial bit, shared by both line directions
    localparam int bit_cycles = 8;

    // offset from a bit edge to its sample point
    localparam int half_bit = 4;

    // one received byte with its strobe
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } rx_byte_t;

endpackage

`default_nettype wire

// File: rtl/sdu_dbg_pkg.sv
`default_nettype none

package sdu_dbg_pkg;

    // command opcodes and reply bytes
    localparam logic [7:0] op_read   = 8'h52;
    localparam logic [7:0] op_write  = 8'h57;
    localparam logic [7:0] ack_write = 8'h4B;
    localparam logic [7:0] reply_bad = 8'h3F;

    localparam int mem_depth = 16;

    // low bits of the address byte
    typedef logic [$clog2(mem_depth)-1:0] addr_t;

    typedef struct packed {
        logic       we;
        addr_t      addr;
        logic [7:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// File: rtl/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    rxd,
    output sdu_uart_pkg::rx_byte_t rx
);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_stop,
        st_wait_high
    } state_t;

    state_t state;
    logic   rxd_q1;
    logic   rxd_q2;
    logic   valid_q;
    logic   sample;
    logic [2:0] bit_cnt;
    logic [7:0] shreg;
    logic [$clog2(sdu_uart_pkg::bit_cycles)-1:0] cyc_cnt;

    // start bit is checked at half a bit, every later bit one full bit on
    assign sample = (int'(cyc_cnt) == (state == st_start ? sdu_uart_pkg::half_bit
                                                         : sdu_uart_pkg::bit_cycles) - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_q1  <= 1'b1;
            rxd_q2  <= 1'b1;
            state   <= st_idle;
            cyc_cnt <= '0;
            bit_cnt <= '0;
            valid_q <= 1'b0;
        end else begin
            rxd_q1  <= rxd;
            rxd_q2  <= rxd_q1;
            valid_q <= 1'b0;
            cyc_cnt <= cyc_cnt + 1'b1;
            case (state)
                st_idle: begin
                    cyc_cnt <= '0;
                    if (!rxd_q2) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (sample) begin
                        cyc_cnt <= '0;
                        bit_cnt <= '0;
                        // glitch, not a real start bit
                        state   <= rxd_q2 ? st_idle : st_data;
                    end
                end
                st_data: begin
                    if (sample) begin
                        cyc_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= st_stop;
                        end
                    end
                end
                st_stop: begin
                    if (sample) begin
                        if (rxd_q2) begin
                            valid_q <= 1'b1;
                            state   <= st_idle;
                        end else begin
                            // framing error, byte dropped
                            state <= st_wait_high;
                        end
                    end
                end
                st_wait_high: begin
                    if (rxd_q2) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (state == st_data && sample) begin
            shreg <= {rxd_q2, shreg[7:1]};
        end
    end

    assign rx = '{valid: valid_q, data: shreg};

    a_single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        rx.valid |=> !rx.valid)
        else $error("rx.valid high two cycles in a row");

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
    input  wire       clk,
    input  wire       rst_n,
    input  wire [7:0] tx_data,
    input  wire       tx_start,
    output logic      txd,
    output logic      tx_busy
);

    logic [9:0] frame;
    logic [3:0] bit_cnt;
    logic       busy_q;
    logic [$clog2(sdu_uart_pkg::bit_cycles)-1:0] cyc_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // all ones keeps the line idle high
            frame   <= '1;
            cyc_cnt <= '0;
            bit_cnt <= '0;
            busy_q  <= 1'b0;
        end else if (!busy_q) begin
            if (tx_start) begin
                frame   <= {1'b1, tx_data, 1'b0};
                cyc_cnt <= '0;
                bit_cnt <= '0;
                busy_q  <= 1'b1;
            end
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
            if (int'(cyc_cnt) == sdu_uart_pkg::bit_cycles - 1) begin
                cyc_cnt <= '0;
                // refill with stop level
                frame   <= {1'b1, frame[9:1]};
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 4'd9) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    assign txd     = frame[0];
    assign tx_busy = busy_q;

    a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_busy |-> txd)
        else $error("txd low while transmitter idle");

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        tx_start |-> !tx_busy)
        else $error("tx_start while transmitter busy");

endmodule

`default_nettype wire

// File: rtl/dbg_mem.sv
`timescale 1ns/100ps
`default_nettype none

module dbg_mem (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire sdu_dbg_pkg::mem_req_t req,
    output logic [7:0]            rdata
);

    logic [7:0] mem [sdu_dbg_pkg::mem_depth];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < sdu_dbg_pkg::mem_depth; i++) begin
                mem[i] <= '0;
            end
        end else if (req.we) begin
            mem[req.addr] <= req.wdata;
        end
    end

    // read is combinational so a read reply leaves in the next cycle
    assign rdata = mem[req.addr];

endmodule

`default_nettype wire

// File: rtl/dbg_cmd.sv
`timescale 1ns/100ps
`default_nettype none

module dbg_cmd (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire sdu_uart_pkg::rx_byte_t rx,
    input  wire [7:0]                  rdata,
    input  wire                        tx_busy,
    output sdu_dbg_pkg::mem_req_t      req,
    output logic [7:0]                 tx_data,
    output logic                       tx_start
);

    typedef enum logic [1:0] {
        st_wait_op,
        st_wait_addr,
        st_wait_data,
        st_reply
    } state_t;

    typedef enum logic [1:0] {
        sel_read,
        sel_ack,
        sel_bad
    } reply_sel_t;

    state_t             state;
    reply_sel_t         reply_sel;
    sdu_dbg_pkg::addr_t addr_q;
    logic [7:0]         wdata_q;
    logic               send;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_wait_op;
            reply_sel <= sel_bad;
        end else begin
            case (state)
                st_wait_op: begin
                    if (rx.valid) begin
                        if (rx.data == sdu_dbg_pkg::op_read) begin
                            reply_sel <= sel_read;
                            state     <= st_wait_addr;
                        end else if (rx.data == sdu_dbg_pkg::op_write) begin
                            reply_sel <= sel_ack;
                            state     <= st_wait_addr;
                        end else begin
                            reply_sel <= sel_bad;
                            state     <= st_reply;
                        end
                    end
                end
                st_wait_addr: begin
                    if (rx.valid) begin
                        state <= (reply_sel == sel_ack) ? st_wait_data : st_reply;
                    end
                end
                st_wait_data: begin
                    if (rx.valid) begin
                        state <= st_reply;
                    end
                end
                // incoming bytes are ignored here
                st_reply: begin
                    if (!tx_busy) begin
                        state <= st_wait_op;
                    end
                end
                default: state <= st_wait_op;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx.valid && state == st_wait_addr) begin
            addr_q <= rx.data[$bits(sdu_dbg_pkg::addr_t)-1:0];
        end
        if (rx.valid && state == st_wait_data) begin
            wdata_q <= rx.data;
        end
    end

    // reply leaves as soon as the transmitter is free
    assign send     = (state == st_reply) && !tx_busy;
    assign tx_start = send;

    // write commits together with its ack
    assign req = '{we: send && (reply_sel == sel_ack), addr: addr_q, wdata: wdata_q};

    always_comb begin
        case (reply_sel)
            sel_read: tx_data = rdata;
            sel_ack:  tx_data = sdu_dbg_pkg::ack_write;
            default:  tx_data = sdu_dbg_pkg::reply_bad;
        endcase
    end

    // a write strobe only rides on a rising reply strobe, and both last one cycle
    a_we_with_reply: assert property (@(posedge clk) disable iff (!rst_n)
        (req.we || tx_start) |-> $rose(tx_start) ##1 !(req.we || tx_start))
        else $error("write or reply strobe not a single cycle with tx_start");

endmodule

`default_nettype wire

// File: rtl/sdu_top.sv
`timescale 1ns/100ps
`default_nettype none

module sdu_top (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        rxd,
    output logic       txd,
    output logic [7:0] scan_byte
);

    sdu_uart_pkg::rx_byte_t rx;
    sdu_dbg_pkg::mem_req_t  req;
    logic [7:0]             rdata;
    logic [7:0]             tx_data;
    logic                   tx_start;
    logic                   tx_busy;

    uart_rx uart_rx_i (
        .clk   (clk),
        .rst_n (rst_n),
        .rxd   (rxd),
        .rx    (rx)
    );

    dbg_mem dbg_mem_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rdata (rdata)
    );

    dbg_cmd dbg_cmd_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .rdata    (rdata),
        .tx_busy  (tx_busy),
        .req      (req),
        .tx_data  (tx_data),
        .tx_start (tx_start)
    );

    uart_tx uart_tx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

    // last nonzero byte seen on the line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_byte <= '0;
        end else if (rx.valid && rx.data != 8'h00) begin
            scan_byte <= rx.data;
        end
    end

endmodule

`default_nettype wire

// File: test/sdu_checker.sv
`timescale 1ns/100ps
`default_nettype none

module sdu_checker (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       rxd,
    input  wire       txd,
    input  wire [7:0] scan_byte,
    output int        pending,
    output int        errors,
    output int        scan_checks,
    output int        scan_errors,
    output int        idle_errors
);

    // model of the debug memory and of the scan register
    logic [7:0] model_mem [sdu_dbg_pkg::mem_depth] = '{default: 8'h00};
    logic [7:0] model_scan = 8'h00;
    logic [7:0] exp_q [$];
    int         issued = 0;
    int         done;
    logic       host_busy;

    assign pending = issued - done;

    task automatic note_byte(input logic [7:0] b);
        if (b != 8'h00) begin
            model_scan = b;
        end
    endtask

    // called by the testbench before the command bytes go out
    task automatic expect_command(input logic [7:0] op, input logic [7:0] addr,
                                  input logic [7:0] data);
        sdu_dbg_pkg::addr_t a;
        a = addr[$bits(sdu_dbg_pkg::addr_t)-1:0];
        note_byte(op);
        if (op == sdu_dbg_pkg::op_read) begin
            note_byte(addr);
            exp_q.push_back(model_mem[a]);
        end else if (op == sdu_dbg_pkg::op_write) begin
            note_byte(addr);
            note_byte(data);
            model_mem[a] = data;
            exp_q.push_back(sdu_dbg_pkg::ack_write);
        end else begin
            exp_q.push_back(sdu_dbg_pkg::reply_bad);
        end
        issued = issued + 1;
    endtask

    task automatic report_value(input string name, input logic [7:0] want,
                                input logic [7:0] got);
        $display("CHECK FAILED time=%0t signal=%s expected=%02h actual=%02h",
                 $time, name, want, got);
        errors++;
    endtask

    // host must stay idle while a reply is on txd
    task automatic wait_sample(input int n);
        repeat (n) begin
            @(posedge clk);
            if (rxd !== 1'b1) begin
                host_busy = 1'b1;
            end
        end
    endtask

    task automatic decode_reply();
        logic [7:0] got;
        got = 8'h00;
        host_busy = 1'b0;
        wait_sample(sdu_uart_pkg::half_bit);
        if (txd !== 1'b0) begin
            $display("%0t: start bit on txd ended before mid-bit", $time);
            errors++;
            idle_errors++;
        end else begin
            for (int i = 0; i < 8; i++) begin
                wait_sample(sdu_uart_pkg::bit_cycles);
                got[i] = txd;
            end
            wait_sample(sdu_uart_pkg::bit_cycles);
            if (txd !== 1'b1) begin
                report_value("txd stop bit", 8'h01, {7'h00, txd});
            end
            if (host_busy) begin
                $display("%0t: host drove rxd while a reply was on txd", $time);
                errors++;
            end
            if (done >= issued) begin
                $display("%0t: reply %02h arrived with no command pending", $time, got);
                errors++;
                idle_errors++;
            end else begin
                if (got !== exp_q[done]) begin
                    report_value("reply byte", exp_q[done], got);
                end
                scan_checks++;
                if (scan_byte !== model_scan) begin
                    report_value("scan_byte", model_scan, scan_byte);
                    scan_errors++;
                end
                done++;
            end
        end
    endtask

    initial begin
        logic reset_edge_seen;
        reset_edge_seen = 1'b0;
        errors = 0;
        scan_checks = 0;
        scan_errors = 0;
        idle_errors = 0;
        done = 0;
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                // idle level is loaded by the first reset edge
                if (reset_edge_seen && txd !== 1'b1) begin
                    report_value("txd", 8'h01, {7'h00, txd});
                    idle_errors++;
                end
                reset_edge_seen = 1'b1;
            end else if (txd !== 1'b1) begin
                decode_reply();
            end
        end
    end

endmodule

`default_nettype wire

// File: test/sdu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module sdu_tb;

    localparam int clk_ns = 4;
    localparam int n_writes = 40;
    localparam int reads_per_write = 2;
    localparam int n_bad = 20;
    // reset reads, write groups, bad opcodes with follow-up reads, framing group
    localparam int n_commands = sdu_dbg_pkg::mem_depth + n_writes * (1 + reads_per_write)
                                + 2 * n_bad + 3;
    localparam int timeout_ns = n_commands * 40 * sdu_uart_pkg::bit_cycles * clk_ns;
    localparam int reply_limit = 24 * sdu_uart_pkg::bit_cycles;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    logic        clk;
    logic        rst_n;
    logic        rxd;
    wire         txd;
    wire  [7:0]  scan_byte;
    logic [31:0] lfsr;
    int          pending;
    int          chk_errors;
    int          scan_checks;
    int          scan_errors;
    int          idle_errors;
    int          tb_errors;
    int          failed_tests;
    int          commands;

    sdu_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rxd       (rxd),
        .txd       (txd),
        .scan_byte (scan_byte)
    );

    sdu_checker chk_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .rxd         (rxd),
        .txd         (txd),
        .scan_byte   (scan_byte),
        .pending     (pending),
        .errors      (chk_errors),
        .scan_checks (scan_checks),
        .scan_errors (scan_errors),
        .idle_errors (idle_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_ns / 2) clk = ~clk;
    end

    initial begin
        #(timeout_ns);
        $display("timeout: the tests did not finish within %0d ns", timeout_ns);
        $display("Done: errors found");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ lfsr_taps;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic int total_errors();
        return chk_errors + tb_errors;
    endfunction

    // one lfsr step per bit
    task automatic draw_bits(input int n, output logic [7:0] v);
        v = 8'h00;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic drive_bit(input logic v);
        @(posedge clk);
        rxd <= v;
        repeat (sdu_uart_pkg::bit_cycles - 1) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] b, input logic stop);
        logic [7:0] gap;
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(stop);
        if (!stop) begin
            drive_bit(1'b1);
        end
        draw_bits(4, gap);
        repeat (gap) @(posedge clk);
    endtask

    task automatic wait_reply();
        int n;
        n = 0;
        while (pending != 0 && n < reply_limit) begin
            @(posedge clk);
            n++;
        end
        if (pending != 0) begin
            $display("%0t: no reply within %0d cycles of the last command byte",
                     $time, reply_limit);
            tb_errors++;
        end
    endtask

    task automatic run_command(input logic [7:0] op, input logic [7:0] addr,
                               input logic [7:0] data);
        chk_i.expect_command(op, addr, data);
        send_byte(op, 1'b1);
        if (op == sdu_dbg_pkg::op_read || op == sdu_dbg_pkg::op_write) begin
            send_byte(addr, 1'b1);
        end
        if (op == sdu_dbg_pkg::op_write) begin
            send_byte(data, 1'b1);
        end
        wait_reply();
        commands++;
    endtask

    task automatic end_test(input string name, input int err_start, input int cmd_start);
        int n;
        n = total_errors() - err_start;
        $display("test %s: %0d commands, %0d errors", name, commands - cmd_start, n);
        if (n != 0) begin
            failed_tests++;
        end
    endtask

    initial begin
        logic [7:0] op;
        logic [7:0] addr;
        logic [7:0] data;
        int         err_start;
        int         cmd_start;
        rst_n = 1'b0;
        rxd = 1'b1;
        lfsr = 32'h2937_f26f;
        tb_errors = 0;
        failed_tests = 0;
        commands = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // memory is all zero only before the first write
        err_start = total_errors();
        cmd_start = commands;
        for (int i = 0; i < sdu_dbg_pkg::mem_depth; i++) begin
            draw_bits(4, addr);
            run_command(sdu_dbg_pkg::op_read, {addr[3:0], i[3:0]}, 8'h00);
        end
        end_test("reset contents", err_start, cmd_start);

        err_start = total_errors();
        cmd_start = commands;
        for (int w = 0; w < n_writes; w++) begin
            draw_bits(8, addr);
            draw_bits(8, data);
            run_command(sdu_dbg_pkg::op_write, addr, data);
            for (int r = 0; r < reads_per_write; r++) begin
                draw_bits(8, addr);
                run_command(sdu_dbg_pkg::op_read, addr, 8'h00);
            end
        end
        end_test("writes then reads", err_start, cmd_start);

        err_start = total_errors();
        cmd_start = commands;
        for (int b = 0; b < n_bad; b++) begin
            do begin
                draw_bits(8, op);
            end while (op == sdu_dbg_pkg::op_read || op == sdu_dbg_pkg::op_write);
            run_command(op, 8'h00, 8'h00);
            draw_bits(8, addr);
            run_command(sdu_dbg_pkg::op_read, addr, 8'h00);
        end
        end_test("unknown opcodes", err_start, cmd_start);

        err_start = total_errors();
        cmd_start = commands;
        draw_bits(8, addr);
        draw_bits(8, data);
        run_command(sdu_dbg_pkg::op_write, addr, data);
        // a write opcode with a low stop bit would shift the parser if accepted
        send_byte(sdu_dbg_pkg::op_write, 1'b0);
        repeat (30 * sdu_uart_pkg::bit_cycles) @(posedge clk);
        run_command(sdu_dbg_pkg::op_read, addr, 8'h00);
        end_test("framing error", err_start, cmd_start);

        $display("test scan_byte: %0d checks, %0d errors", scan_checks, scan_errors);
        if (scan_errors != 0) begin
            failed_tests++;
        end
        $display("test idle line: %0d errors", idle_errors);
        if (idle_errors != 0) begin
            failed_tests++;
        end

        $display("tests: 6, failed: %0d, commands: %0d, errors: %0d",
                 failed_tests, commands, total_errors());
        if (total_errors() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/sdu_uart_pkg.sv
rtl/sdu_dbg_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/dbg_mem.sv
rtl/dbg_cmd.sv
rtl/sdu_top.sv
test/sdu_checker.sv
test/sdu_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module sdu_tb -o sdu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sdu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1
